//--- hw/lsu_macros.svh
// load/store unit width definitions
// shared by the package and every block of the unit

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

////////////////////////////////////////
// data path
////////////////////////////////////////

// data and address width
`define LSU_DATA_W 32

// one enable per byte lane
`define LSU_BE_W   4

// byte offset inside a word
`define LSU_OFFS_W 2

`endif // LSU_MACROS_SVH

//--- hw/lsu_pkg.sv
// load/store unit types
// access size encoding and the payload structs passed between blocks

`include "lsu_macros.svh"

package lsu_pkg;

  // access size, 2'b11 is handled like a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } lsu_size_e;

  ////////////////////////////////////////
  // execute stage request
  ////////////////////////////////////////

  typedef struct packed {
    logic                   we;          // store when set
    lsu_size_e              size;
    logic [`LSU_DATA_W-1:0] wdata;       // store data as held in the register
    logic [`LSU_OFFS_W-1:0] reg_offset;  // byte offset inside source reg
    logic                   sign_ext;    // sign extend loads
    logic [`LSU_DATA_W-1:0] op_a;
    logic [`LSU_DATA_W-1:0] op_b;
    logic                   use_incr;    // address is op_a + op_b
    logic                   misaligned;  // second part of a split access
  } lsu_ex_req_t;

  ////////////////////////////////////////
  // memory side request
  ////////////////////////////////////////

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;  // already rotated into lanes
  } lsu_mem_req_t;

  // what the response needs to know about the granted access
  typedef struct packed {
    lsu_size_e              size;
    logic [`LSU_OFFS_W-1:0] offset;
    logic                   sign_ext;
    logic                   we;
  } lsu_load_attr_t;

endpackage

//--- hw/lsu_req_path.sv
// load/store request path
// address generation, byte enables, store data rotation
// and detection of accesses that need a second memory access

`include "lsu_macros.svh"

module lsu_req_path
  import lsu_pkg::*;
(
  input  lsu_ex_req_t  ex_req_i,
  input  logic         ex_req_valid_i,
  output lsu_mem_req_t mem_req_o,
  output logic         misaligned_o
);

  // byte enable patterns
  localparam logic [`LSU_BE_W-1:0] BE_ALL   = '1;
  localparam logic [`LSU_BE_W-1:0] BE_HALF  = {{(`LSU_BE_W-2){1'b0}}, 2'b11};
  localparam logic [`LSU_BE_W-1:0] BE_LANE0 = {{(`LSU_BE_W-1){1'b0}}, 1'b1};

  logic [`LSU_DATA_W-1:0] addr;
  logic [`LSU_OFFS_W-1:0] addr_offs;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_OFFS_W-1:0] wdata_offs;   // lanes to rotate the store data by
  logic [`LSU_OFFS_W+2:0] wdata_shamt;  // same in bits
  logic [`LSU_DATA_W-1:0] wdata_rot;

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  assign addr      = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign addr_offs = addr[`LSU_OFFS_W-1:0];  // byte lane of the first byte

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb
  begin
    be = '0;
    case (ex_req_i.size)
      SIZE_WORD:
      begin
        if (!ex_req_i.misaligned)
          be = BE_ALL << addr_offs;                  // offset lane and above
        else
          be = (BE_LANE0 << addr_offs) - BE_LANE0;   // lanes below the offset
      end

      SIZE_HALF:
      begin
        if (!ex_req_i.misaligned)
          be = BE_HALF << addr_offs;  // offset 3 keeps only lane 3
        else
          be = BE_LANE0;              // upper byte spills into lane 0
      end

      default:
      begin
        be = BE_LANE0 << addr_offs;   // byte, size 2 or 3
      end
    endcase
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // data sits in the register at reg_offset, it must land at addr_offs
  assign wdata_offs  = addr_offs - ex_req_i.reg_offset;
  assign wdata_shamt = {wdata_offs, 3'b000};

  // rotate left, a zero shift leaves the right term at zero
  assign wdata_rot = (ex_req_i.wdata << wdata_shamt)
                   | (ex_req_i.wdata >> (`LSU_DATA_W - wdata_shamt));

  ////////////////////////////////////////
  // misaligned detection
  ////////////////////////////////////////

  // only the first part of a pair can be split again
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_req_valid_i && !ex_req_i.misaligned)
    begin
      case (ex_req_i.size)
        SIZE_WORD: misaligned_o = (addr_offs != '0);  // any non-zero offset
        SIZE_HALF: misaligned_o = (addr_offs == '1);  // only the top lane
        default:   misaligned_o = 1'b0;               // bytes never split
      endcase
    end
  end

  // memory request, all combinational from the execute stage
  assign mem_req_o = '{
    addr:  addr,
    we:    ex_req_i.we,
    be:    be,
    wdata: wdata_rot
  };

endmodule

//--- hw/lsu_load_align.sv
// load data alignment
// keeps the attributes of the granted access, assembles split loads
// from two responses and zero or sign extends halfwords and bytes

`include "lsu_macros.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  lsu_ex_req_t            ex_req_i,
  input  logic [`LSU_OFFS_W-1:0] addr_offs_i,
  input  logic                   misaligned_i,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  lsu_load_attr_t         attr_q;       // access in flight
  logic [`LSU_DATA_W-1:0] rdata_q;      // raw first word or last result
  logic [`LSU_DATA_W-1:0] rdata_shift;  // response moved down to lane 0
  logic [`LSU_DATA_W-1:0] word_ext;
  logic [`LSU_DATA_W-1:0] half_ext;
  logic [`LSU_DATA_W-1:0] byte_ext;
  logic [`LSU_DATA_W-1:0] rdata_ext;
  logic [15:0]            half_raw;
  logic [7:0]             byte_raw;
  logic                   pair_open;    // a split access is in progress

  ////////////////////////////////////////
  // attributes on grant
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      attr_q <= '0;
    end
    else if (data_gnt_i)
    begin
      attr_q <= '{
        size:     ex_req_i.size,
        offset:   addr_offs_i,
        sign_ext: ex_req_i.sign_ext,
        we:       ex_req_i.we
      };
    end
  end

  ////////////////////////////////////////
  // alignment and extension
  ////////////////////////////////////////

  assign rdata_shift = data_rdata_i >> {attr_q.offset, 3'b000};

  // split word, low bytes of the new word go on top of the stored tail
  always_comb
  begin
    case (attr_q.offset)
      2'd0:    word_ext = data_rdata_i;
      2'd1:    word_ext = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    word_ext = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_ext = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // halfword at offset 3 takes its low byte from the first response
  assign half_raw = (attr_q.offset == '1) ? {data_rdata_i[7:0], rdata_q[31:24]}
                                          : rdata_shift[15:0];
  assign byte_raw = rdata_shift[7:0];

  always_comb
  begin
    if (attr_q.sign_ext)
    begin
      half_ext = {{(`LSU_DATA_W-16){half_raw[15]}}, half_raw};
      byte_ext = {{(`LSU_DATA_W-8){byte_raw[7]}}, byte_raw};
    end
    else
    begin
      half_ext = {{(`LSU_DATA_W-16){1'b0}}, half_raw};
      byte_ext = {{(`LSU_DATA_W-8){1'b0}}, byte_raw};
    end
  end

  always_comb
  begin
    case (attr_q.size)
      SIZE_WORD: rdata_ext = word_ext;
      SIZE_HALF: rdata_ext = half_ext;
      default:   rdata_ext = byte_ext;  // size 2 and 3
    endcase
  end

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////

  // first part is flagged here, second part is already presented by EX
  assign pair_open = misaligned_i || ex_req_i.misaligned;

  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !attr_q.we)
    begin
      if (pair_open)
        rdata_q <= data_rdata_i;  // keep raw word for the second response
      else
        rdata_q <= rdata_ext;     // finished value for writeback
    end
  end

  // new result straight through in the response cycle
  assign rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

//--- hw/lsu_ctrl_fsm.sv
// load/store request sequencer
// forwards requests to memory, tracks outstanding responses
// and absorbs execute stage stalls around grant and response

module lsu_ctrl_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic ex_req_valid_i,
  input  logic ex_valid_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic ready_ex_o,
  output logic ready_wb_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE,                  // nothing outstanding
    WAIT_RVALID,           // response pending, EX moved on
    WAIT_RVALID_EX_STALL,  // response pending, EX still stalled
    IDLE_EX_STALL          // response done, EX still stalled
  } state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = ex_req_valid_i;
        if (ex_req_valid_i)
        begin
          ready_ex_o = data_gnt_i;  // hold EX until the grant
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        ready_wb_o = data_rvalid_i;  // WB waits on the load data
        if (data_rvalid_i)
        begin
          // next access may go out in the response cycle
          data_req_o = ex_req_valid_i;
          if (ex_req_valid_i)
          begin
            ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;  // retry from IDLE
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      // EX is stuck on the granted access, no new requests here
      WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;  // stall gone, wait normally
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;  // data is already stored
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // busy while anything is outstanding or going out
  assign busy_o = (state_q != IDLE) || data_req_o;

endmodule

//--- hw/lsu_top.sv
// load/store unit top level
// joins the request path, the sequencer and the load alignment
// between the execute stage and the data memory

`include "lsu_macros.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // execute stage
  input  lsu_ex_req_t            ex_req_i,
  input  logic                   ex_req_valid_i,
  input  logic                   ex_valid_i,
  // data memory
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic                   data_req_o,
  output lsu_mem_req_t           mem_req_o,
  // back to the pipeline
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   misaligned_o,
  output logic                   ready_ex_o,
  output logic                   ready_wb_o,
  output logic                   busy_o
);

  logic [`LSU_OFFS_W-1:0] addr_offs;  // byte lane of the current address

  assign addr_offs = mem_req_o.addr[`LSU_OFFS_W-1:0];

  lsu_req_path u_req_path (
    .ex_req_i       (ex_req_i),
    .ex_req_valid_i (ex_req_valid_i),
    .mem_req_o      (mem_req_o),
    .misaligned_o   (misaligned_o)
  );

  // split flag is combined with ex_req_i.misaligned inside
  lsu_load_align u_load_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .ex_req_i      (ex_req_i),
    .addr_offs_i   (addr_offs),
    .misaligned_i  (misaligned_o),
    .rdata_o       (rdata_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_valid_i (ex_req_valid_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .ready_ex_o     (ready_ex_o),
    .ready_wb_o     (ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

//--- tests/lsu_tb.sv
// load/store unit testbench
// random loads and stores with random grant delays and execute stalls,
// a memory model with one response per grant and a byte-level reference model

`include "lsu_macros.svh"

module lsu_tb
  import lsu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_OPS     = 200;
  localparam int CYC_LIMIT = N_OPS * 12 + 40;  // reset and idle phase on top

  logic                   clk;
  logic                   rst_n;
  lsu_ex_req_t            ex_req;
  logic                   ex_req_valid;
  logic                   ex_valid;
  logic                   data_gnt;
  logic                   data_rvalid;
  logic [`LSU_DATA_W-1:0] data_rdata;
  logic                   data_req;
  lsu_mem_req_t           mem_req;
  logic [`LSU_DATA_W-1:0] rdata;
  logic                   misaligned;
  logic                   ready_ex;
  logic                   ready_wb;
  logic                   busy;

  logic [31:0] mem [64];      // memory model seen by the DUT
  logic [31:0] ref_mem [64];  // reference copy, written byte by byte
  logic [31:0] seed;
  int          cycles;

  lsu_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_i       (ex_req),
    .ex_req_valid_i (ex_req_valid),
    .ex_valid_i     (ex_valid),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_rdata_i   (data_rdata),
    .data_req_o     (data_req),
    .mem_req_o      (mem_req),
    .rdata_o        (rdata),
    .misaligned_o   (misaligned),
    .ready_ex_o     (ready_ex),
    .ready_wb_o     (ready_wb),
    .busy_o         (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  // run length guard
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYC_LIMIT)
    begin
      $display("run did not finish within %0d cycles", CYC_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0000, seed[31:16]};  // upper bits, low ones cycle fast
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return int'(rand_next() % n);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // access size in bytes, 3 counts as byte
  function automatic int size_bytes(input logic [1:0] sz);
    if (sz == 2'd0)
      return 4;
    else if (sz == 2'd1)
      return 2;
    return 1;
  endfunction

  // lanes touched by one part of the access
  function automatic logic [3:0] exp_be(input logic [1:0] o, input int n, input logic second);
    logic [3:0] be;
    int         oi;
    be = '0;
    oi = int'(o);
    for (int l = 0; l < 4; l++)
    begin
      if (!second && l >= oi && l < oi + n)
        be[l] = 1'b1;
      if (second && l < oi + n - 4)
        be[l] = 1'b1;  // spill into the next word
    end
    return be;
  endfunction

  // register byte ro+k must sit in lane o+k
  function automatic logic [31:0] exp_wdata(input logic [31:0] wd, input logic [1:0] o,
                                            input logic [1:0] ro);
    logic [31:0] out;
    int          src;
    out = '0;
    for (int j = 0; j < 4; j++)
    begin
      src = (j - int'(o) + int'(ro) + 4) % 4;
      out[8*j +: 8] = wd[8*src +: 8];
    end
    return out;
  endfunction

  task automatic ref_store(input logic [31:0] a, input int n, input logic [31:0] wd,
                           input logic [1:0] ro);
    logic [31:0] ba;
    for (int k = 0; k < n; k++)
    begin
      ba = a + 32'(k);
      ref_mem[ba[7:2]][8*int'(ba[1:0]) +: 8] = wd[8*((int'(ro) + k) % 4) +: 8];
    end
  endtask

  function automatic logic [31:0] ref_load(input logic [31:0] a, input int n, input logic sx);
    logic [31:0] val;
    logic [31:0] ba;
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      ba = a + 32'(k);
      val[8*k +: 8] = ref_mem[ba[7:2]][8*int'(ba[1:0]) +: 8];
    end
    if (sx && n < 4 && val[8*n-1])
      val = val | ~((32'h1 << (8*n)) - 32'h1);  // sign fill
    return val;
  endfunction

  ////////////////////////////////////////
  // one memory access
  ////////////////////////////////////////

  task automatic run_access(input lsu_ex_req_t req, input logic [31:0] a,
                            input logic first_part, input logic last_part,
                            input logic [31:0] load_exp);
    int           delay;
    int           stall;
    int           left;
    int           n;
    logic         v_g;
    logic         v_r;
    logic         single_load;
    lsu_mem_req_t granted;
    delay       = int'(rand_below(3));
    stall       = int'(rand_below(3));
    n           = size_bytes(req.size);
    single_load = !req.we && !first_part && !last_part;

    @(negedge clk);
    ex_req       = req;
    ex_req_valid = 1'b1;
    ex_valid     = 1'b1;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    for (int i = 0; i < delay; i++)
    begin
      #1;
      check_val("data_req_o", 32'(data_req), 32'h1);
      check_val("ready_ex_o", 32'(ready_ex), 32'h0);  // no grant yet
      check_val("busy_o", 32'(busy), 32'h1);
      @(negedge clk);
    end

    // grant cycle, stall may start here
    v_g      = (stall == 0);
    left     = (stall > 0) ? stall - 1 : 0;
    ex_valid = v_g;
    data_gnt = 1'b1;
    #1;
    check_val("data_req_o", 32'(data_req), 32'h1);
    check_val("ready_ex_o", 32'(ready_ex), 32'h1);
    check_val("busy_o", 32'(busy), 32'h1);
    check_val("mem_req_o.addr", mem_req.addr, a);
    check_val("mem_req_o.we", 32'(mem_req.we), 32'(req.we));
    check_val("mem_req_o.be", 32'(mem_req.be), 32'(exp_be(a[1:0], n, req.misaligned)));
    if (req.we)
      check_val("mem_req_o.wdata", mem_req.wdata, exp_wdata(req.wdata, a[1:0], req.reg_offset));
    check_val("misaligned_o", 32'(misaligned),
              32'(!req.misaligned && (int'(a[1:0]) + n > 4)));
    granted = mem_req;

    @(posedge clk);
    if (granted.we)
    begin
      for (int l = 0; l < 4; l++)
        if (granted.be[l])
          mem[a[7:2]][8*l +: 8] = granted.wdata[8*l +: 8];
    end

    // response exactly one cycle after the grant
    @(negedge clk);
    data_gnt    = 1'b0;
    data_rvalid = 1'b1;
    data_rdata  = mem[a[7:2]];
    v_r         = (left == 0);
    ex_valid    = v_r;
    #1;
    check_val("data_req_o", 32'(data_req), 32'(v_g));  // silent while stalled
    check_val("ready_wb_o", 32'(ready_wb), 32'h1);
    if (!req.we && !first_part)
      check_val("rdata_o", rdata, load_exp);

    @(negedge clk);
    data_rvalid  = 1'b0;
    ex_req_valid = 1'b0;
    data_rdata   = rand_next();
    ex_valid     = 1'b1;
    #1;
    check_val("busy_o", 32'(busy), 32'(!v_r));
    check_val("data_req_o", 32'(data_req), 32'h0);
    if (single_load)
      check_val("rdata_o", rdata, load_exp);  // held after the response
  endtask

  ////////////////////////////////////////
  // random operation, split when needed
  ////////////////////////////////////////

  task automatic run_op();
    lsu_ex_req_t req;
    lsu_ex_req_t req2;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] exp;
    int          w;
    int          n;
    r   = rand_next();
    w   = int'(rand_below(63));  // word w+1 must exist too
    a   = 32'(w * 4) + 32'(rand_below(4));
    req = '0;
    req.we         = r[0];
    req.size       = lsu_size_e'(r[2:1]);
    req.sign_ext   = r[3];
    req.reg_offset = r[5:4];
    req.use_incr   = r[6];
    req.wdata      = {rand_next() << 16} | rand_next();
    req.op_b       = req.use_incr ? 32'(rand_below(64)) : rand_next();
    req.op_a       = req.use_incr ? a - req.op_b : a;
    n   = size_bytes(r[2:1]);
    exp = '0;
    if (req.we)
      ref_store(a, n, req.wdata, req.reg_offset);
    else
      exp = ref_load(a, n, req.sign_ext);

    if (int'(a[1:0]) + n <= 4)
    begin
      run_access(req, a, 1'b0, 1'b0, exp);
    end
    else
    begin
      run_access(req, a, 1'b1, 1'b0, exp);
      req2            = req;
      req2.misaligned = 1'b1;
      req2.op_a       = req.op_a + 32'd4;  // same offset bits, next word
      run_access(req2, a + 32'd4, 1'b0, 1'b1, exp);
    end

    if (req.we)
    begin
      check_val("mem word", mem[w], ref_mem[w]);
      check_val("mem next word", mem[w+1], ref_mem[w+1]);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    seed         = 32'd26;
    cycles       = 0;
    rst_n        = 1'b0;
    ex_req       = '0;
    ex_req_valid = 1'b0;
    ex_valid     = 1'b1;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = (32'(i) * 32'h0101_0101) ^ 32'hc3a5_0f96;  // every word differs
      ref_mem[i] = mem[i];
    end

    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // idle, nothing requested
    repeat (5)
    begin
      @(negedge clk);
      #1;
      check_val("ready_ex_o", 32'(ready_ex), 32'h1);
      check_val("ready_wb_o", 32'(ready_wb), 32'h1);
      check_val("busy_o", 32'(busy), 32'h0);
      check_val("data_req_o", 32'(data_req), 32'h0);
    end

    for (int i = 0; i < N_OPS; i++)
      run_op();

    @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_req_path.sv
hw/lsu_load_align.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_top.sv
tests/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

TOP := lsu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
